//--- cache_pkg.sv
// ====================
// cache bank package
// geometry, queue sizes and the request, response and pipeline payloads
// ====================
`default_nettype none

package cache_pkg;

    // line and word geometry
    localparam int WORD_BYTES  = 4;
    localparam int WORD_W      = 32;
    localparam int LINE_WORDS  = 4;
    localparam int LINE_W      = 128;
    localparam int WSEL_W      = 2;
    localparam int NUM_LINES   = 16;
    localparam int INDEX_W     = 4;
    localparam int LINE_ADDR_W = 12;
    localparam int TAG_HI_W    = LINE_ADDR_W - INDEX_W;
    localparam int REQ_TAG_W   = 8;

    // queue depths and pipeline length
    localparam int CRSQ_DEPTH  = 2;
    localparam int MREQ_DEPTH  = 4;
    localparam int PIPE_STAGES = 2;

    typedef struct packed {
        logic                   rw;
        logic [LINE_ADDR_W-1:0] addr;
        logic [WSEL_W-1:0]      wsel;
        logic [WORD_BYTES-1:0]  byteen;
        logic [WORD_W-1:0]      data;
        logic [REQ_TAG_W-1:0]   tag;
    } core_req_t;

    typedef struct packed {
        logic [WORD_W-1:0]    data;
        logic [REQ_TAG_W-1:0] tag;
    } core_rsp_t;

    // read is a line fill, write carries one word
    typedef struct packed {
        logic                   rw;
        logic [LINE_ADDR_W-1:0] addr;
        logic [WSEL_W-1:0]      wsel;
        logic [WORD_BYTES-1:0]  byteen;
        logic [WORD_W-1:0]      data;
    } mem_req_t;

    typedef struct packed {
        core_req_t         req;
        logic [LINE_W-1:0] line;
        logic              is_fill;
        logic              is_replay;
    } pipe_entry_t;

endpackage

`default_nettype wire

//--- cache_req_select.sv
// ====================
// request select
// fixed priority grant of replay, fill and core request
// registers the winner as the stage-0 entry
// ====================
`default_nettype none

module cache_req_select
    import cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   replay_valid,
    input  core_req_t              replay_req,
    output logic                   replay_ready,
    input  logic                   mem_rsp_valid,
    input  logic [LINE_W-1:0]      mem_rsp_data,
    output logic                   mem_rsp_ready,
    input  logic [LINE_ADDR_W-1:0] fill_addr,
    input  logic                   core_req_valid,
    input  core_req_t              core_req,
    output logic                   core_req_ready,
    input  logic                   hold_core,
    input  logic                   stall,
    output logic                   st0_valid,
    output pipe_entry_t            st0
);

    logic        fill_grant;
    logic        core_grant;
    logic        any_fire;
    pipe_entry_t next_entry;

    // replay first so a parked miss never waits behind new traffic,
    // then fill so the slot can drain
    assign fill_grant = !replay_valid;
    assign core_grant = !replay_valid && !mem_rsp_valid;

    assign replay_ready   = !stall;
    assign mem_rsp_ready  = fill_grant && !stall;
    assign core_req_ready = core_grant && !hold_core && !stall;

    assign any_fire = (replay_valid && replay_ready)
                   || (mem_rsp_valid && mem_rsp_ready)
                   || (core_req_valid && core_req_ready);

    always_comb begin
        next_entry           = '0;
        next_entry.line      = mem_rsp_data;
        if (replay_valid) begin
            next_entry.req       = replay_req;
            next_entry.is_replay = 1'b1;
        end else if (mem_rsp_valid) begin
            // fill goes to the line of the parked miss
            next_entry.req.addr = fill_addr;
            next_entry.is_fill  = 1'b1;
        end else begin
            next_entry.req = core_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st0_valid <= 1'b0;
        end else if (!stall) begin
            st0_valid <= any_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            st0 <= next_entry;
        end
    end

endmodule

`default_nettype wire

//--- cache_tags.sv
// ====================
// tag store
// valid bit and stored tag per line, combinational lookup
// ====================
`default_nettype none

module cache_tags
    import cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [LINE_ADDR_W-1:0] lookup_addr,
    output logic                   hit,
    input  logic                   fill,
    input  logic [LINE_ADDR_W-1:0] fill_addr
);

    logic [NUM_LINES-1:0] valid_bits;
    logic [TAG_HI_W-1:0]  tag_store [NUM_LINES];

    logic [INDEX_W-1:0]   lookup_idx;
    logic [TAG_HI_W-1:0]  lookup_tag;
    logic [INDEX_W-1:0]   fill_idx;
    logic [TAG_HI_W-1:0]  fill_tag;

    // low bits pick the line, the rest is the stored tag
    assign lookup_idx = lookup_addr[INDEX_W-1:0];
    assign lookup_tag = lookup_addr[LINE_ADDR_W-1:INDEX_W];
    assign fill_idx   = fill_addr[INDEX_W-1:0];
    assign fill_tag   = fill_addr[LINE_ADDR_W-1:INDEX_W];

    assign hit = valid_bits[lookup_idx] && (tag_store[lookup_idx] == lookup_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else if (fill) begin
            valid_bits[fill_idx] <= 1'b1;
        end
    end

    // a fill simply overwrites whatever line sat at this index
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_store[fill_idx] <= fill_tag;
        end
    end

endmodule

`default_nettype wire

//--- cache_data.sv
// ====================
// data store
// word read, byte-enabled word write and full line fill
// ====================
`default_nettype none

module cache_data
    import cache_pkg::*;
(
    input  logic                   clk,
    input  logic [LINE_ADDR_W-1:0] addr,
    input  logic [WSEL_W-1:0]      wsel,
    output logic [WORD_W-1:0]      read_data,
    input  logic                   write,
    input  logic [WORD_BYTES-1:0]  byteen,
    input  logic [WORD_W-1:0]      write_data,
    input  logic                   fill,
    input  logic [LINE_W-1:0]      fill_data
);

    localparam int BYTE_W = WORD_W / WORD_BYTES;

    logic [LINE_WORDS-1:0][WORD_W-1:0] lines [NUM_LINES];
    logic [INDEX_W-1:0]                idx;

    assign idx = addr[INDEX_W-1:0];

    // register array, so a write is visible on the next read
    assign read_data = lines[idx][wsel];

    always_ff @(posedge clk) begin
        if (fill) begin
            lines[idx] <= fill_data;
        end else if (write) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (byteen[b]) begin
                    lines[idx][wsel][b*BYTE_W +: BYTE_W] <= write_data[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- cache_miss_slot.sv
// ====================
// miss slot
// parks one read miss until its fill returns, then offers it for replay
// ====================
`default_nettype none

module cache_miss_slot
    import cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   alloc,
    input  core_req_t              alloc_req,
    output logic                   busy,
    input  logic                   fill_done,
    output logic [LINE_ADDR_W-1:0] miss_addr,
    output logic                   replay_valid,
    output core_req_t              replay_req,
    input  logic                   replay_ready
);

    typedef enum logic [1:0] {
        SLOT_EMPTY,
        SLOT_WAIT_FILL,
        SLOT_REPLAY
    } slot_state_t;

    slot_state_t state;
    core_req_t   parked;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SLOT_EMPTY;
        end else begin
            case (state)
                SLOT_EMPTY:     if (alloc) state <= SLOT_WAIT_FILL;
                SLOT_WAIT_FILL: if (fill_done) state <= SLOT_REPLAY;
                SLOT_REPLAY:    if (replay_ready) state <= SLOT_EMPTY;
                default:        state <= SLOT_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            parked <= alloc_req;
        end
    end

    assign busy         = (state != SLOT_EMPTY);
    assign miss_addr    = parked.addr;
    assign replay_valid = (state == SLOT_REPLAY);
    assign replay_req   = parked;

endmodule

`default_nettype wire

//--- cache_queue.sv
// ====================
// payload FIFO
// circular buffer with registered count and almost-full flag
// ====================
`default_nettype none

module cache_queue
    import cache_pkg::*;
#(
    parameter type payload_t = core_rsp_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready,
    output logic     alm_full
);

    // response queue and memory request queue differ in width
    localparam int DEPTH = ($bits(payload_t) == $bits(core_rsp_t)) ? CRSQ_DEPTH : MREQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // counts the entry landing this cycle, so requests already in flight still fit
    assign alm_full = (count + CNT_W'(push)) > CNT_W'(DEPTH - PIPE_STAGES);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- cache_bank.sv
// ====================
// cache bank
// direct-mapped write-through bank with a two stage pipeline
// and a single miss slot
// ====================
`default_nettype none

module cache_bank
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              core_req_valid,
    input  core_req_t         core_req,
    output logic              core_req_ready,
    output logic              core_rsp_valid,
    output core_rsp_t         core_rsp,
    input  logic              core_rsp_ready,
    output logic              mem_req_valid,
    output mem_req_t          mem_req,
    input  logic              mem_req_ready,
    input  logic              mem_rsp_valid,
    input  logic [LINE_W-1:0] mem_rsp_data,
    output logic              mem_rsp_ready
);

    logic                   replay_valid;
    core_req_t              replay_req;
    logic                   replay_ready;
    logic [LINE_ADDR_W-1:0] miss_addr;
    logic                   slot_busy;
    logic                   hold_core;
    logic                   stall;

    logic                   st0_valid;
    pipe_entry_t            st0;
    logic                   st0_hit;
    logic                   st0_rd_miss;

    logic                   st1_valid;
    pipe_entry_t            st1;
    logic                   st1_hit;
    logic [WORD_W-1:0]      st1_read_data;

    logic                   do_fill_st1;
    logic                   do_read_hit_st1;
    logic                   do_read_miss_st1;
    logic                   do_write_st1;

    core_rsp_t              crsp_in;
    logic                   crsp_ready;
    mem_req_t               mreq_in;
    logic                   mreq_alm_full;

    cache_req_select u_req_select (
        .clk            (clk),
        .rst_n          (rst_n),
        .replay_valid   (replay_valid),
        .replay_req     (replay_req),
        .replay_ready   (replay_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_ready  (mem_rsp_ready),
        .fill_addr      (miss_addr),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .hold_core      (hold_core),
        .stall          (stall),
        .st0_valid      (st0_valid),
        .st0            (st0)
    );

    // tags are written by the fill at stage 0, so the replay right behind it hits
    cache_tags u_tags (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (st0.req.addr),
        .hit         (st0_hit),
        .fill        (st0_valid && st0.is_fill),
        .fill_addr   (st0.req.addr)
    );

    assign st0_rd_miss = st0_valid && !st0.is_fill && !st0.is_replay
                      && !st0.req.rw && !st0_hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st1_valid <= 1'b0;
        end else if (!stall) begin
            st1_valid <= st0_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            st1     <= st0;
            st1_hit <= st0_hit;
        end
    end

    assign do_fill_st1      = st1_valid && st1.is_fill;
    assign do_read_hit_st1  = st1_valid && !st1.is_fill && !st1.req.rw && st1_hit;
    assign do_read_miss_st1 = st1_valid && !st1.is_fill && !st1.is_replay
                           && !st1.req.rw && !st1_hit;
    assign do_write_st1     = st1_valid && !st1.is_fill && st1.req.rw;

    // only read hits wait on the response queue
    assign stall = do_read_hit_st1 && !crsp_ready;

    // a known miss anywhere in the pipe or a parked one blocks new core
    // requests, keeping responses in order
    assign hold_core = slot_busy || mreq_alm_full || st0_rd_miss || do_read_miss_st1
                    || (st0_valid && st0.is_replay) || (st1_valid && st1.is_replay);

    cache_data u_data (
        .clk        (clk),
        .addr       (st1.req.addr),
        .wsel       (st1.req.wsel),
        .read_data  (st1_read_data),
        .write      (do_write_st1 && st1_hit),
        .byteen     (st1.req.byteen),
        .write_data (st1.req.data),
        .fill       (do_fill_st1),
        .fill_data  (st1.line)
    );

    cache_miss_slot u_miss_slot (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (do_read_miss_st1),
        .alloc_req    (st1.req),
        .busy         (slot_busy),
        .fill_done    (mem_rsp_valid && mem_rsp_ready),
        .miss_addr    (miss_addr),
        .replay_valid (replay_valid),
        .replay_req   (replay_req),
        .replay_ready (replay_ready)
    );

    assign crsp_in.data = st1_read_data;
    assign crsp_in.tag  = st1.req.tag;

    cache_queue #(
        .payload_t (core_rsp_t)
    ) crsp_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (do_read_hit_st1),
        .in_data   (crsp_in),
        .in_ready  (crsp_ready),
        .out_valid (core_rsp_valid),
        .out_data  (core_rsp),
        .out_ready (core_rsp_ready),
        .alm_full  ()
    );

    // read miss becomes a line fill, every write goes through
    assign mreq_in.rw     = st1.req.rw;
    assign mreq_in.addr   = st1.req.addr;
    assign mreq_in.wsel   = st1.req.wsel;
    assign mreq_in.byteen = st1.req.byteen;
    assign mreq_in.data   = st1.req.data;

    cache_queue #(
        .payload_t (mem_req_t)
    ) mreq_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (do_write_st1 || do_read_miss_st1),
        .in_data   (mreq_in),
        .in_ready  (),
        .out_valid (mem_req_valid),
        .out_data  (mem_req),
        .out_ready (mem_req_ready),
        .alm_full  (mreq_alm_full)
    );

endmodule

`default_nettype wire

//--- tb_cache_checker.sv
// ====================
// cache bank checker
// shadow memory and tag model, compares core responses
// and memory requests against expected values
// ====================
`default_nettype none

module tb_cache_checker
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              core_req_valid,
    input  core_req_t         core_req,
    input  logic              core_req_ready,
    input  logic              core_rsp_valid,
    input  core_rsp_t         core_rsp,
    input  logic              core_rsp_ready,
    input  logic              mem_req_valid,
    input  mem_req_t          mem_req,
    input  logic              mem_req_ready,
    output int                err_count,
    output int                pending
);

    logic [LINE_W-1:0]   shadow [1 << LINE_ADDR_W];
    logic [TAG_HI_W-1:0] tag_model [NUM_LINES];
    logic                valid_model [NUM_LINES];
    core_rsp_t           exp_rsp [$];
    mem_req_t            exp_mreq [$];
    integer              seed;

    function automatic logic [WORD_W-1:0] merge_bytes(input logic [WORD_W-1:0] old_word,
                                                      input logic [WORD_W-1:0] new_word,
                                                      input logic [WORD_BYTES-1:0] be);
        logic [WORD_W-1:0] res;
        res = old_word;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // same seed and call order as the memory model, so contents match
    initial begin
        seed = 32'h2caed470;
        err_count = 0;
        pending = 0;
        for (int a = 0; a < (1 << LINE_ADDR_W); a++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                shadow[a][w*WORD_W +: WORD_W] = $random(seed);
            end
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            valid_model[i] = 1'b0;
            tag_model[i] = '0;
        end
    end

    always @(posedge clk) begin
        logic [INDEX_W-1:0]  idx;
        logic [TAG_HI_W-1:0] tg;
        logic [WORD_W-1:0]   word;
        core_rsp_t           er;
        mem_req_t            em;
        mem_req_t            wr;
        if (rst_n) begin
            if (core_req_valid && core_req_ready) begin
                idx = core_req.addr[INDEX_W-1:0];
                tg = core_req.addr[LINE_ADDR_W-1:INDEX_W];
                word = shadow[core_req.addr][core_req.wsel*WORD_W +: WORD_W];
                if (core_req.rw) begin
                    wr.rw = 1'b1;
                    wr.addr = core_req.addr;
                    wr.wsel = core_req.wsel;
                    wr.byteen = core_req.byteen;
                    wr.data = core_req.data;
                    exp_mreq.push_back(wr);
                    shadow[core_req.addr][core_req.wsel*WORD_W +: WORD_W] =
                        merge_bytes(word, core_req.data, core_req.byteen);
                end else begin
                    er.data = word;
                    er.tag = core_req.tag;
                    exp_rsp.push_back(er);
                    // a read to an uncached line needs exactly one fill
                    if (!valid_model[idx] || tag_model[idx] != tg) begin
                        wr = '0;
                        wr.addr = core_req.addr;
                        exp_mreq.push_back(wr);
                        valid_model[idx] = 1'b1;
                        tag_model[idx] = tg;
                    end
                end
            end
            if (core_rsp_valid && core_rsp_ready) begin
                if (exp_rsp.size() == 0) begin
                    $display("core response arrived with no read outstanding");
                    err_count++;
                end else begin
                    er = exp_rsp.pop_front();
                    if (core_rsp.data !== er.data) begin
                        $display("ERR core_rsp.data expected %h got %h", er.data, core_rsp.data);
                        err_count++;
                    end
                    if (core_rsp.tag !== er.tag) begin
                        $display("ERR core_rsp.tag expected %h got %h", er.tag, core_rsp.tag);
                        err_count++;
                    end
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                if (exp_mreq.size() == 0) begin
                    $display("memory request appeared that no core request explains");
                    err_count++;
                end else begin
                    em = exp_mreq.pop_front();
                    if (mem_req.rw !== em.rw || mem_req.addr !== em.addr) begin
                        $display("ERR mem_req.rw/addr expected %h/%h got %h/%h",
                                 em.rw, em.addr, mem_req.rw, mem_req.addr);
                        err_count++;
                    end else if (em.rw && (mem_req.wsel !== em.wsel
                                 || mem_req.byteen !== em.byteen
                                 || mem_req.data !== em.data)) begin
                        $display("ERR mem_req.wsel/byteen/data expected %h/%h/%h got %h/%h/%h",
                                 em.wsel, em.byteen, em.data,
                                 mem_req.wsel, mem_req.byteen, mem_req.data);
                        err_count++;
                    end
                end
            end
            pending = exp_rsp.size() + exp_mreq.size();
        end
    end

endmodule

`default_nettype wire

//--- tb_cache_bank.sv
// ====================
// cache bank testbench
// clock, reset, stimulus table and a line memory model
// ====================
`default_nettype none

module tb_cache_bank;
    import cache_pkg::*;

    localparam int WAIT_LIMIT = 300;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              core_req_valid;
    core_req_t         core_req;
    logic              core_req_ready;
    logic              core_rsp_valid;
    core_rsp_t         core_rsp;
    logic              core_rsp_ready;
    logic              mem_req_valid;
    mem_req_t          mem_req;
    logic              mem_req_ready;
    logic              mem_rsp_valid;
    logic [LINE_W-1:0] mem_rsp_data;
    logic              mem_rsp_ready;

    int                err_count;
    int                pending;
    int                timeouts;
    integer            seed;

    mem_req_t          stim [$];
    logic [LINE_W-1:0] mem_lines [1 << LINE_ADDR_W];
    logic [LINE_W-1:0] fill_line;
    logic              fill_pending;
    logic              rsp_taken;
    int                fill_delay;
    int                cycle;

    cache_bank UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    tb_cache_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .err_count      (err_count),
        .pending        (pending)
    );

    always #10 clk = ~clk;

    task automatic add_entry(input logic rw, input logic [LINE_ADDR_W-1:0] addr,
                             input logic [WSEL_W-1:0] wsel,
                             input logic [WORD_BYTES-1:0] be, input logic [WORD_W-1:0] data);
        mem_req_t e;
        e.rw = rw;
        e.addr = addr;
        e.wsel = wsel;
        e.byteen = be;
        e.data = data;
        stim.push_back(e);
    endtask

    // memory model, handshakes seen at the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req.rw) begin
                    for (int b = 0; b < WORD_BYTES; b++) begin
                        if (mem_req.byteen[b]) begin
                            mem_lines[mem_req.addr][mem_req.wsel*WORD_W + b*8 +: 8] =
                                mem_req.data[b*8 +: 8];
                        end
                    end
                end else begin
                    fill_line = mem_lines[mem_req.addr];
                    fill_pending = 1'b1;
                    fill_delay = $random(seed) & 3;
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                rsp_taken = 1'b1;
            end
        end
    end

    // responses and readies change on the falling edge
    always @(negedge clk) begin
        cycle++;
        if (rsp_taken) begin
            mem_rsp_valid <= 1'b0;
            rsp_taken = 1'b0;
        end else if (fill_pending && !mem_rsp_valid) begin
            if (fill_delay == 0) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp_data <= fill_line;
                fill_pending = 1'b0;
            end else begin
                fill_delay--;
            end
        end
        mem_req_ready <= ($random(seed) & 3) != 0;
        core_rsp_ready <= (cycle % 11) < 7;
    end

    initial begin
        int waited;
        rst_n = 1'b0;
        core_req_valid = 1'b0;
        core_req = '0;
        core_rsp_ready = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        fill_pending = 1'b0;
        rsp_taken = 1'b0;
        fill_delay = 0;
        cycle = 0;
        timeouts = 0;
        seed = 32'h2caed470;
        for (int a = 0; a < (1 << LINE_ADDR_W); a++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                mem_lines[a][w*WORD_W +: WORD_W] = $random(seed);
            end
        end

        // cold miss, hit, write hit, merged read
        add_entry(1'b0, 12'h010, 2'd1, 4'hf, 32'h0);
        add_entry(1'b0, 12'h010, 2'd2, 4'hf, 32'h0);
        add_entry(1'b1, 12'h010, 2'd1, 4'b0101, 32'haabbccdd);
        add_entry(1'b0, 12'h010, 2'd1, 4'hf, 32'h0);
        // write miss goes only to memory, read then fills the merged line
        add_entry(1'b1, 12'h123, 2'd3, 4'b1100, 32'h12345678);
        add_entry(1'b0, 12'h123, 2'd3, 4'hf, 32'h0);
        // same index, different tags
        add_entry(1'b0, 12'h020, 2'd0, 4'hf, 32'h0);
        add_entry(1'b0, 12'h030, 2'd0, 4'hf, 32'h0);
        add_entry(1'b0, 12'h020, 2'd1, 4'hf, 32'h0);
        add_entry(1'b0, 12'h030, 2'd2, 4'hf, 32'h0);
        add_entry(1'b1, 12'h030, 2'd2, 4'hf, 32'hdeadbeef);
        add_entry(1'b0, 12'h030, 2'd2, 4'hf, 32'h0);
        add_entry(1'b0, 12'h010, 2'd0, 4'hf, 32'h0);
        add_entry(1'b1, 12'h055, 2'd0, 4'b0001, 32'h000000a5);
        add_entry(1'b1, 12'h055, 2'd0, 4'b0010, 32'h00005a00);
        add_entry(1'b0, 12'h055, 2'd0, 4'hf, 32'h0);
        add_entry(1'b0, 12'h030, 2'd3, 4'hf, 32'h0);
        add_entry(1'b0, 12'h030, 2'd1, 4'hf, 32'h0);
        // back-to-back writes fill the memory request queue
        for (int w = 0; w < LINE_WORDS; w++) begin
            add_entry(1'b1, 12'h030, WSEL_W'(w), 4'b0110, 32'h01010101 * (w + 1));
        end
        add_entry(1'b1, 12'h044, 2'd2, 4'b0011, 32'h0000beef);
        add_entry(1'b1, 12'h044, 2'd2, 4'b1100, 32'hcafe0000);
        // a run of hits backs up the response queue
        for (int r = 0; r < 2 * LINE_WORDS; r++) begin
            add_entry(1'b0, 12'h030, WSEL_W'(r), 4'hf, 32'h0);
        end
        add_entry(1'b0, 12'h044, 2'd2, 4'hf, 32'h0);

        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < stim.size() && timeouts == 0; i++) begin
            core_req_valid = 1'b1;
            core_req.rw = stim[i].rw;
            core_req.addr = stim[i].addr;
            core_req.wsel = stim[i].wsel;
            core_req.byteen = stim[i].byteen;
            core_req.data = stim[i].data;
            core_req.tag = REQ_TAG_W'(i);
            waited = 0;
            @(posedge clk);
            while (!core_req_ready && waited < WAIT_LIMIT) begin
                waited++;
                @(posedge clk);
            end
            if (waited >= WAIT_LIMIT) begin
                $display("core request %0d was never accepted", i);
                timeouts++;
            end
            @(negedge clk);
        end
        core_req_valid = 1'b0;

        waited = 0;
        while (timeouts == 0 && pending != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (timeouts == 0 && pending != 0) begin
            $display("%0d expected responses or memory requests never arrived", pending);
            timeouts++;
        end
        repeat (10) @(negedge clk);

        $display("errors: %0d, timeouts: %0d", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
cache_pkg.sv
cache_req_select.sv
cache_tags.sv
cache_data.sv
cache_miss_slot.sv
cache_queue.sv
cache_bank.sv
tb_cache_checker.sv
tb_cache_bank.sv

//--- run.sh
#!/bin/sh
# build and run the cache bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_cache_bank -o sim_cache_bank
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_cache_bank > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1
